/* tests/cpu_core_trace.txt */
# T name | I instruction word from the reset pc on | D addr doubleword
# S store addr data_wr mem_op | E error cycle | H done (EBREAK)
T arith
I 10000513
I FFB00093
I 00700113
I 002081B3
I 00353023
I 40208233
I 00453423
I 7FFFF337
I 7FF3029B
I 005283BB
I 00753823
I 40125413
I 00853C23
I 00100073
S 100 0000000000000002 3
S 108 FFFFFFFFFFFFFFF4 3
S 110 FFFFFFFFFFFFEFFE 3
S 118 FFFFFFFFFFFFFFFA 3
H
T loads
I 10000513
I 00150083
I 02153023
I 00255103
I 02253423
I 00452183
I 02353823
I 00456203
I 02452C23
I 00053283
I 04553023
I 00754303
I 04650423
I 00651383
I 04753823
I 00100073
D 100 F0E1D2C3B4A59687
S 120 FFFFFFFFFFFFFF96 3
S 128 000000000000B4A5 3
S 130 FFFFFFFFF0E1D2C3 3
S 138 00000000F0E1D2C3 2
S 140 F0E1D2C3B4A59687 3
S 148 00000000000000F0 0
S 150 FFFFFFFFFFFFF0E1 3
H
T branch
I 10000513
I 00500093
I 00500113
I 00208663
I 00153023
I 00153023
I 00209463
I 01100193
I 00353423
I 00C002EF
I 00153023
I 00153023
I 00553823
I FFF00213
I 00124463
I 00153023
I 00126463
I 00000317
I 010303E7
I 00153023
I 00153023
I 00753C23
I 00100073
S 108 0000000000000011 3
S 110 0000000080000028 3
S 118 000000008000004C 3
H
T csr
I 10000513
I 0F000093
I 30509173
I 00253023
I 3057E1F3
I 00353423
I 03C00213
I 305232F3
I 00553823
I 3051F373
I 00653C23
I 305023F3
I 02753023
I 00100073
S 100 0000000000000000 3
S 108 00000000000000F0 3
S 110 00000000000000FF 3
S 118 00000000000000C3 3
S 120 00000000000000C0 3
H
T trap
I 10000513
I 00000097
I 01C08093
I 30509073
I 00000073
I 05500193
I 00353823
I 00100073
I 34202273
I 00453023
I 341022F3
I 00553423
I 00428293
I 34129073
I 30200073
S 100 000000000000000B 3
S 108 0000000080000010 3
S 110 0000000000000055 3
H
T fault
I 10000513
I 02A00093
I 7C0010F3
I FFFFFFFF
I 00153023
I 00100073
E
E
S 100 000000000000002A 3
H

/* cpu_core.f */
design/cpu_pkg.sv
design/cpu_fetch.sv
design/cpu_decode.sv
design/cpu_regfile.sv
design/cpu_alu.sv
design/cpu_csr.sv
design/cpu_lsu.sv
design/cpu_core.sv
tests/cpu_core_chk.sv
tests/cpu_core_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - design/cpu_pkg.sv
  - design/cpu_fetch.sv
  - design/cpu_decode.sv
  - design/cpu_regfile.sv
  - design/cpu_alu.sv
  - design/cpu_csr.sv
  - design/cpu_lsu.sv
  - design/cpu_core.sv
  - target: test
    files:
      - tests/cpu_core_chk.sv
      - tests/cpu_core_tb.sv

/* tests/cpu_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;
    import cpu_pkg::*;

    localparam logic [63:0] code_base = 64'h8000_0000;
    localparam int max_rec = 512;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [63:0] data_rd;
    logic [63:0] pc, addr, data_wr;
    logic        mem_wr, mem_rd, error, done;
    mem_op_t     mem_op;

    logic [31:0] imem [0:63];
    logic [63:0] dmem [0:63];

    // Trace records with a kind letter and up to three fields
    byte         rec_kind [0:max_rec-1];
    logic [63:0] rec_a [0:max_rec-1];
    logic [63:0] rec_b [0:max_rec-1];
    logic [2:0]  rec_c [0:max_rec-1];
    string       test_name [0:31];
    int          test_first [0:32];
    int          n_rec, n_tests, n_words;
    int          ev_pos, ev_last;
    int          halt_at;
    int          test_errs, total_errs, tests_failed;
    int          cycles, cycle_limit;

    cpu_core #(
        .reset_pc(code_base)
    ) cpu_core_inst (
        .clk(clk), .rst(rst), .instr(instr), .data_rd(data_rd),
        .pc(pc), .addr(addr), .data_wr(data_wr), .mem_wr(mem_wr), .mem_rd(mem_rd),
        .mem_op(mem_op), .error(error), .done(done)
    );

    always #4 clk = ~clk;

    always_comb begin
        if (pc[63:8] == code_base[63:8])
            instr = imem[pc[7:2]];
        else
            instr = 32'h0000_0000;    // Outside the image reads as illegal
    end

    assign data_rd = dmem[addr[8:3]];

    // Byte lanes covered by the access width from the low address bits on
    function automatic logic [63:0] merge_store(input logic [63:0] old, input logic [63:0] wd,
                                                input logic [2:0] op, input logic [2:0] lo);
        logic [63:0] res;
        int size;
        res  = old;
        size = 1 << op[1:0];
        for (int i = 0; i < 8; i++) begin
            if (i >= lo && i < lo + size)
                res[i*8 +: 8] = wd[(i - lo)*8 +: 8];
        end
        return res;
    endfunction

    always @(posedge clk) begin
        if (mem_wr)
            dmem[addr[8:3]] <= merge_store(dmem[addr[8:3]], data_wr, mem_op, addr[2:0]);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: no done after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic read_trace;
        int fd, n;
        string tag, rest;
        fd = $fopen("tests/cpu_core_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tag);
                if (n != 1)
                    break;
                if (tag == "#") begin
                    n = $fgets(rest, fd);
                end else if (tag == "T") begin
                    n = $fscanf(fd, "%s", test_name[n_tests]);
                    test_first[n_tests] = n_rec;
                    n_tests++;
                end else begin
                    rec_kind[n_rec] = tag[0];
                    rec_a[n_rec]    = 64'd0;
                    rec_b[n_rec]    = 64'd0;
                    rec_c[n_rec]    = 3'd0;
                    if (tag == "I") begin
                        n = $fscanf(fd, "%h", rec_a[n_rec]);
                        n_words++;
                    end else if (tag == "D")
                        n = $fscanf(fd, "%h %h", rec_a[n_rec], rec_b[n_rec]);
                    else if (tag == "S")
                        n = $fscanf(fd, "%h %h %h", rec_a[n_rec], rec_b[n_rec], rec_c[n_rec]);
                    n_rec++;
                end
            end
            $fclose(fd);
            test_first[n_tests] = n_rec;
        end
    endtask

    task automatic load_image(input int t);
        int wpos;
        wpos    = 0;
        halt_at = -1;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0000_0000;
            dmem[i] = {32'(i) ^ 32'h5a5a_0000, ~32'(i)};
        end
        for (int p = test_first[t]; p < test_first[t+1]; p++) begin
            if (rec_kind[p] == "I") begin
                if (halt_at < 0 && rec_a[p][31:0] == 32'h0010_0073)
                    halt_at = wpos;    // First EBREAK ends the run
                imem[wpos] = rec_a[p][31:0];
                wpos++;
            end else if (rec_kind[p] == "D") begin
                dmem[rec_a[p][8:3]] = rec_b[p];
            end
        end
        ev_pos  = test_first[t];
        ev_last = test_first[t+1];
    endtask

    task automatic check_value(input string sig, input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, sig, exp, got);
            test_errs++;
        end
    endtask

    // Moves to the next event record and checks that it is of the kind seen
    task automatic expect_event(input byte kind, output bit found);
        while (ev_pos < ev_last && rec_kind[ev_pos] != "S" && rec_kind[ev_pos] != "E"
               && rec_kind[ev_pos] != "H")
            ev_pos++;
        found = 1'b0;
        assert (ev_pos < ev_last) else begin
            $display("At %0t: event %s seen, but no more events were expected", $time, kind);
            test_errs++;
        end
        if (ev_pos < ev_last) begin
            assert (rec_kind[ev_pos] == kind) else begin
                $display("At %0t: event %s seen where event %s was expected", $time, kind,
                         rec_kind[ev_pos]);
                test_errs++;
            end
            found = rec_kind[ev_pos] == kind;
            ev_pos++;
        end
    endtask

    task automatic run_test(input int t);
        bit found;
        int chk_base;
        logic [63:0] halt_pc;
        test_errs = 0;
        chk_base  = cpu_core_inst.cpu_core_chk_inst.fails;
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        load_image(t);    // Core already held in reset
        repeat (7) @(posedge clk);
        rst <= 1'b1;
        halt_pc = code_base + 64'(halt_at) * 64'd4;
        forever begin
            @(negedge clk);    // Outputs settled between edges
            check_value("mem_rd", {63'd0, (instr[6:0] == opc_load && instr[14:12] != 3'b111)},
                        {63'd0, mem_rd});
            if (error)
                expect_event("E", found);
            if (mem_wr) begin
                expect_event("S", found);
                if (found) begin
                    check_value("addr", rec_a[ev_pos-1], addr);
                    check_value("data_wr", rec_b[ev_pos-1], data_wr);
                    check_value("mem_op", {61'd0, rec_c[ev_pos-1]}, {61'd0, mem_op});
                end
            end
            if (done) begin
                expect_event("H", found);
                check_value("pc", halt_pc, pc);
                @(negedge clk);
                assert (done) else begin
                    $display("At %0t: done dropped after EBREAK", $time);
                    test_errs++;
                end
                check_value("pc", halt_pc, pc);
                break;
            end
        end
        while (ev_pos < ev_last && rec_kind[ev_pos] != "S" && rec_kind[ev_pos] != "E"
               && rec_kind[ev_pos] != "H")
            ev_pos++;
        assert (ev_pos >= ev_last) else begin
            $display("Test %s ended with expected events left over", test_name[t]);
            test_errs++;
        end
        test_errs += cpu_core_inst.cpu_core_chk_inst.fails - chk_base;
        $display("test %0d %s: %s, %0d errors", t, test_name[t],
                 test_errs == 0 ? "pass" : "fail", test_errs);
        total_errs += test_errs;
        if (test_errs != 0)
            tests_failed++;
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        cycles       = 0;
        cycle_limit  = 0;
        n_rec        = 0;
        n_tests      = 0;
        n_words      = 0;
        halt_at      = -1;
        total_errs   = 0;
        tests_failed = 0;
        read_trace();
        cycle_limit = n_words * 4 + n_tests * 10 + 100;
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        $display("%0d tests run, %0d passed, %0d failed, %0d check errors", n_tests,
                 n_tests - tests_failed, tests_failed, total_errs);
        if (total_errs == 0 && n_tests > 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/cpu_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core_chk (
    input  wire        clk,
    input  wire        rst,
    input  wire        mem_wr,
    input  wire        mem_rd,
    input  wire        error,
    input  wire        done,
    input  wire [63:0] pc
);
    int fails = 0;    // Assertion failures so far

    // A single access per cycle
    mem_excl: assert property (@(posedge clk) !(mem_wr && mem_rd))
        else begin
            $error("mem_wr and mem_rd high in the same cycle");
            fails++;
        end

    reset_quiet: assert property (@(posedge clk)
        !rst |-> (!mem_wr && !mem_rd && !error && !done))
        else begin
            $error("memory enable or status output active during reset");
            fails++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            fails++;
        end

endmodule

bind cpu_core cpu_core_chk cpu_core_chk_inst (
    .clk(clk), .rst(rst), .mem_wr(mem_wr), .mem_rd(mem_rd),
    .error(error), .done(done), .pc(pc)
);

`default_nettype wire

/* design/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter logic [63:0] reset_pc = 64'h8000_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       instr,
    input  logic [63:0]       data_rd,
    output logic [63:0]       pc,
    output logic [63:0]       addr,
    output logic [63:0]       data_wr,
    output logic              mem_wr,
    output logic              mem_rd,
    output cpu_pkg::mem_op_t  mem_op,
    output logic              error,
    output logic              done
);
    import cpu_pkg::*;

    logic [4:0]  rs1, rs2, rd;
    logic [63:0] imm;
    alu_op_t     alu_op;
    br_t         br;
    csr_op_t     csr_op;
    logic        a_sel, b_sel, word_op;
    logic        reg_wr, mem_to_reg, pc_link;
    logic        csr_imm, ecall, mret;
    logic [11:0] csr_addr;
    logic [63:0] src1, src2;
    logic [63:0] alu_result, target;
    logic        taken;
    logic [63:0] csr_rdata, trap_pc;
    logic        trap, csr_err;
    logic [63:0] wb_data;

    assign addr    = alu_result;
    assign data_wr = src2;

    cpu_fetch #(
        .reset_pc(reset_pc)
    ) cpu_fetch_inst (
        .clk(clk), .rst(rst), .halt(done), .trap(trap), .trap_pc(trap_pc),
        .taken(taken), .target(target), .pc(pc)
    );

    // Error and done come out of the decoder already gated by reset
    cpu_decode cpu_decode_inst (
        .rst(rst), .instr(instr), .csr_err(csr_err),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .alu_op(alu_op), .a_sel(a_sel), .b_sel(b_sel), .word_op(word_op), .br(br),
        .reg_wr(reg_wr), .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_op(mem_op),
        .mem_to_reg(mem_to_reg), .pc_link(pc_link),
        .csr_op(csr_op), .csr_imm(csr_imm), .csr_addr(csr_addr),
        .ecall(ecall), .mret(mret), .ebreak(done), .illegal(error)
    );

    cpu_regfile cpu_regfile_inst (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
        .wen(reg_wr), .wdata(wb_data), .src1(src1), .src2(src2)
    );

    cpu_alu cpu_alu_inst (
        .pc(pc), .src1(src1), .src2(src2), .imm(imm),
        .alu_op(alu_op), .a_sel(a_sel), .b_sel(b_sel), .word_op(word_op), .br(br),
        .alu_result(alu_result), .taken(taken), .target(target)
    );

    cpu_csr cpu_csr_inst (
        .clk(clk), .rst(rst), .csr_op(csr_op), .csr_imm(csr_imm), .csr_addr(csr_addr),
        .src1(src1), .zimm(rs1), .pc(pc), .ecall(ecall), .mret(mret), .block(error),
        .csr_rdata(csr_rdata), .csr_err(csr_err), .trap(trap), .trap_pc(trap_pc)
    );

    cpu_lsu cpu_lsu_inst (
        .addr_low(addr[2:0]), .data_rd(data_rd), .mem_op(mem_op),
        .mem_to_reg(mem_to_reg), .pc_link(pc_link), .csr_sel(csr_op != csr_none),
        .alu_result(alu_result), .pc(pc), .csr_rdata(csr_rdata), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

/* design/cpu_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_lsu (
    input  logic [2:0]        addr_low,
    input  logic [63:0]       data_rd,
    input  cpu_pkg::mem_op_t  mem_op,
    input  logic              mem_to_reg,
    input  logic              pc_link,
    input  logic              csr_sel,
    input  logic [63:0]       alu_result,
    input  logic [63:0]       pc,
    input  logic [63:0]       csr_rdata,
    output logic [63:0]       wb_data
);
    import cpu_pkg::*;

    logic [63:0] lane;
    logic [63:0] load;

    assign lane = data_rd >> {addr_low, 3'b000};    // Addressed byte to bit 0

    always_comb begin
        case (mem_op)
            mem_b:   load = {{56{lane[7]}}, lane[7:0]};
            mem_h:   load = {{48{lane[15]}}, lane[15:0]};
            mem_w:   load = {{32{lane[31]}}, lane[31:0]};
            mem_bu:  load = {56'b0, lane[7:0]};
            mem_hu:  load = {48'b0, lane[15:0]};
            mem_wu:  load = {32'b0, lane[31:0]};
            default: load = lane;
        endcase
    end

    always_comb begin
        if (mem_to_reg)
            wb_data = load;
        else if (pc_link)
            wb_data = pc + 64'd4;      // Return address
        else if (csr_sel)
            wb_data = csr_rdata;       // Old CSR value
        else
            wb_data = alu_result;
    end

endmodule

`default_nettype wire

/* design/cpu_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_csr (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::csr_op_t  csr_op,
    input  logic              csr_imm,
    input  logic [11:0]       csr_addr,
    input  logic [63:0]       src1,
    input  logic [4:0]        zimm,
    input  logic [63:0]       pc,
    input  logic              ecall,
    input  logic              mret,
    input  logic              block,
    output logic [63:0]       csr_rdata,
    output logic              csr_err,
    output logic              trap,
    output logic [63:0]       trap_pc
);
    import cpu_pkg::*;

    logic [63:0] mstatus, mtvec, mepc, mcause;
    logic [63:0] operand;
    logic [63:0] wdata;
    logic        hit;

    always_comb begin
        hit = 1'b1;
        case (csr_addr)
            addr_mstatus: csr_rdata = mstatus;
            addr_mtvec:   csr_rdata = mtvec;
            addr_mepc:    csr_rdata = mepc;
            addr_mcause:  csr_rdata = mcause;
            default: begin
                csr_rdata = 64'd0;
                hit       = 1'b0;
            end
        endcase
    end

    assign csr_err = csr_op != csr_none && !hit;
    assign operand = csr_imm ? {59'b0, zimm} : src1;

    always_comb begin
        case (csr_op)
            csr_set:   wdata = csr_rdata | operand;
            csr_clear: wdata = csr_rdata & ~operand;
            default:   wdata = operand;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mstatus <= 64'd0;
            mtvec   <= 64'd0;
            mepc    <= 64'd0;
            mcause  <= 64'd0;
        end else if (!block) begin
            if (ecall) begin
                mepc   <= pc;
                mcause <= cause_ecall_m;
            end else if (csr_op != csr_none) begin
                case (csr_addr)
                    addr_mstatus: mstatus <= wdata;
                    addr_mtvec:   mtvec <= wdata;
                    addr_mepc:    mepc <= wdata;
                    addr_mcause:  mcause <= wdata;
                    default: ;
                endcase
            end
        end
    end

    assign trap    = ecall | mret;
    assign trap_pc = mret ? mepc : {mtvec[63:2], 2'b00};    // Direct mode only

endmodule

`default_nettype wire

/* design/cpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  logic [63:0]       pc,
    input  logic [63:0]       src1,
    input  logic [63:0]       src2,
    input  logic [63:0]       imm,
    input  cpu_pkg::alu_op_t  alu_op,
    input  logic              a_sel,
    input  logic              b_sel,
    input  logic              word_op,
    input  cpu_pkg::br_t      br,
    output logic [63:0]       alu_result,
    output logic              taken,
    output logic [63:0]       target
);
    import cpu_pkg::*;

    logic [63:0] a, b;
    logic [63:0] a_srl, a_sra;
    logic [5:0]  shamt;
    logic [63:0] res;
    logic [63:0] sum;

    assign a     = a_sel ? pc : src1;
    assign b     = b_sel ? imm : src2;
    assign shamt = word_op ? {1'b0, b[4:0]} : b[5:0];

    // Right shifts in W form work on the low word only
    assign a_srl = word_op ? {32'b0, a[31:0]} : a;
    assign a_sra = word_op ? {{32{a[31]}}, a[31:0]} : a;

    always_comb begin
        case (alu_op)
            alu_add:    res = a + b;
            alu_sub:    res = a - b;
            alu_sll:    res = a << shamt;
            alu_slt:    res = {63'b0, $signed(a) < $signed(b)};
            alu_sltu:   res = {63'b0, a < b};
            alu_xor:    res = a ^ b;
            alu_srl:    res = a_srl >> shamt;
            alu_sra:    res = $signed(a_sra) >>> shamt;
            alu_or:     res = a | b;
            alu_and:    res = a & b;
            default:    res = b;                      // LUI
        endcase
    end

    assign alu_result = word_op ? {{32{res[31]}}, res[31:0]} : res;

    always_comb begin
        case (br)
            br_jal, br_jalr: taken = 1'b1;
            br_beq:  taken = src1 == src2;
            br_bne:  taken = src1 != src2;
            br_blt:  taken = $signed(src1) < $signed(src2);
            br_bge:  taken = $signed(src1) >= $signed(src2);
            br_bltu: taken = src1 < src2;
            br_bgeu: taken = src1 >= src2;
            default: taken = 1'b0;
        endcase
    end

    assign sum    = ((br == br_jalr) ? src1 : pc) + imm;
    assign target = {sum[63:1], sum[0] & (br != br_jalr)};

endmodule

`default_nettype wire

/* design/cpu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        wen,
    input  logic [63:0] wdata,
    output logic [63:0] src1,
    output logic [63:0] src2
);
    logic [63:0] rf [32];

    assign src1 = (rs1 == 5'd0) ? 64'd0 : rf[rs1];
    assign src2 = (rs2 == 5'd0) ? 64'd0 : rf[rs2];

    always_ff @(posedge clk) begin
        if (rst && wen && rd != 5'd0)
            rf[rd] <= wdata;
    end

endmodule

`default_nettype wire

/* design/cpu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  logic              rst,
    input  logic [31:0]       instr,
    input  logic              csr_err,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output logic [4:0]        rd,
    output logic [63:0]       imm,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              a_sel,
    output logic              b_sel,
    output logic              word_op,
    output cpu_pkg::br_t      br,
    output logic              reg_wr,
    output logic              mem_rd,
    output logic              mem_wr,
    output cpu_pkg::mem_op_t  mem_op,
    output logic              mem_to_reg,
    output logic              pc_link,
    output cpu_pkg::csr_op_t  csr_op,
    output logic              csr_imm,
    output logic [11:0]       csr_addr,
    output logic              ecall,
    output logic              mret,
    output logic              ebreak,
    output logic              illegal
);
    import cpu_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    br_t         br_raw;
    logic        rw, ld, st;
    logic        is_ecall, is_mret, is_ebreak;
    logic        bad;
    logic        ok;

    function automatic alu_op_t f3_op(input logic [2:0] f, input logic alt);
        case (f)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode   = instr[6:0];
    assign f3       = instr[14:12];
    assign f7       = instr[31:25];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];
    assign mem_op   = mem_op_t'(f3);
    assign csr_imm  = f3[2];
    assign csr_addr = instr[31:20];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm        = imm_i;
        alu_op     = alu_add;
        a_sel      = 1'b0;
        b_sel      = 1'b1;
        word_op    = 1'b0;
        br_raw     = br_none;
        rw         = 1'b0;
        ld         = 1'b0;
        st         = 1'b0;
        mem_to_reg = 1'b0;
        pc_link    = 1'b0;
        csr_op     = csr_none;
        is_ecall   = 1'b0;
        is_mret    = 1'b0;
        is_ebreak  = 1'b0;
        bad        = 1'b0;
        case (opcode)
            opc_lui: begin
                imm    = imm_u;
                alu_op = alu_pass_b;
                rw     = 1'b1;
            end
            opc_auipc: begin
                imm   = imm_u;
                a_sel = 1'b1;
                rw    = 1'b1;
            end
            opc_jal: begin
                imm     = imm_j;
                br_raw  = br_jal;
                pc_link = 1'b1;
                rw      = 1'b1;
            end
            opc_jalr: begin
                br_raw  = br_jalr;
                pc_link = 1'b1;
                rw      = 1'b1;
                bad     = f3 != 3'b000;
            end
            opc_branch: begin
                imm = imm_b;
                case (f3)
                    3'b000:  br_raw = br_beq;
                    3'b001:  br_raw = br_bne;
                    3'b100:  br_raw = br_blt;
                    3'b101:  br_raw = br_bge;
                    3'b110:  br_raw = br_bltu;
                    3'b111:  br_raw = br_bgeu;
                    default: bad = 1'b1;
                endcase
            end
            opc_load: begin
                ld         = 1'b1;
                mem_to_reg = 1'b1;
                rw         = 1'b1;
                bad        = f3 == 3'b111;    // No unsigned doubleword load
            end
            opc_store: begin
                imm = imm_s;
                st  = 1'b1;
                bad = f3[2];
            end
            opc_op_imm, opc_op_imm_32: begin
                word_op = opcode == opc_op_imm_32;
                alu_op  = f3_op(f3, f3 == 3'b101 && instr[30]);
                rw      = 1'b1;
                // shamt[5] is reserved in the W forms
                if (f3 == 3'b001)
                    bad = instr[31:26] != 6'b0 || (word_op && instr[25]);
                else if (f3 == 3'b101)
                    bad = {instr[31], instr[29:26]} != 5'b0 || (word_op && instr[25]);
                else
                    bad = word_op && f3 != 3'b000;
            end
            opc_op, opc_op_32: begin
                word_op = opcode == opc_op_32;
                b_sel   = 1'b0;
                alu_op  = f3_op(f3, f7[5]);
                rw      = 1'b1;
                bad     = {f7[6], f7[4:0]} != 6'b0
                          || (f7[5] && f3 != 3'b000 && f3 != 3'b101)
                          || (word_op && f3 != 3'b000 && f3 != 3'b001 && f3 != 3'b101);
            end
            opc_system: begin
                if (f3[1:0] != 2'b00) begin
                    csr_op = csr_op_t'(f3[1:0]);
                    rw     = 1'b1;
                end else if (f3 == 3'b000 && instr[19:7] == 13'b0) begin
                    case (instr[31:20])
                        12'h000: is_ecall = 1'b1;
                        12'h001: is_ebreak = 1'b1;
                        12'h302: is_mret = 1'b1;
                        default: bad = 1'b1;
                    endcase
                end else begin
                    bad = 1'b1;
                end
            end
            default: bad = 1'b1;
        endcase
    end

    // Error also covers CSR addresses the core lacks
    assign illegal = rst & (bad | csr_err);
    assign ok      = rst & ~(bad | csr_err);

    assign reg_wr = ok & rw;
    assign mem_rd = ok & ld;
    assign mem_wr = ok & st;
    assign br     = ok ? br_raw : br_none;
    assign ecall  = ok & is_ecall;
    assign mret   = ok & is_mret;
    assign ebreak = ok & is_ebreak;

endmodule

`default_nettype wire

/* design/cpu_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch #(
    parameter logic [63:0] reset_pc = 64'h8000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        halt,
    input  logic        trap,
    input  logic [63:0] trap_pc,
    input  logic        taken,
    input  logic [63:0] target,
    output logic [63:0] pc
);
    logic [63:0] next_pc;

    always_comb begin
        if (trap)
            next_pc = trap_pc;    // ECALL or MRET
        else if (taken)
            next_pc = target;
        else
            next_pc = pc + 64'd4;
    end

    always_ff @(posedge clk) begin
        if (!rst)
            pc <= reset_pc;
        else if (!halt)
            pc <= next_pc;
    end

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    typedef enum logic [3:0] {
        br_none, br_jal, br_jalr, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } br_t;

    // Same values as the load/store funct3 field
    typedef enum logic [2:0] {
        mem_b  = 3'd0,
        mem_h  = 3'd1,
        mem_w  = 3'd2,
        mem_d  = 3'd3,
        mem_bu = 3'd4,
        mem_hu = 3'd5,
        mem_wu = 3'd6,
        mem_du = 3'd7
    } mem_op_t;

    typedef enum logic [1:0] {
        csr_none, csr_write, csr_set, csr_clear   // Matches funct3[1:0]
    } csr_op_t;

    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_system    = 7'b1110011;

    localparam logic [11:0] addr_mstatus = 12'h300;
    localparam logic [11:0] addr_mtvec   = 12'h305;
    localparam logic [11:0] addr_mepc    = 12'h341;
    localparam logic [11:0] addr_mcause  = 12'h342;

    localparam logic [63:0] cause_ecall_m = 64'd11;

endpackage

`default_nettype wire
